//--- src/radio_defs.svh
// Radio core constants
// Settings bus register map, readback map and data path widths

`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

// Settings bus register addresses
`define RADIO_SR_TIME_HI    8'd0
`define RADIO_SR_TIME_LO    8'd1
`define RADIO_SR_TIME_CTRL  8'd2
`define RADIO_SR_LOOPBACK   8'd3
`define RADIO_SR_TEST       8'd4
`define RADIO_SR_CODEC_IDLE 8'd5

// RX control, kept at the same offsets as the full radio
`define RADIO_SR_RX_CMD     8'd48
`define RADIO_SR_RX_HALT    8'd51

// Readback mux addresses
`define RADIO_RB_VITA_TIME  8'd0
`define RADIO_RB_LASTPPS    8'd1
`define RADIO_RB_RX         8'd2
`define RADIO_RB_TXRX       8'd3
`define RADIO_RB_RADIO_NUM  8'd4
`define RADIO_RB_ERRORS     8'd5

// Data path widths
`define RADIO_SAMP_W 32     // One complex sample, 16-bit I and Q
`define RADIO_TIME_W 64     // Sample-time counter

`endif

//--- src/radio_pkg.sv
// Radio core types
// Settings bus and stream beat structs, control opcodes and FSM states

`include "radio_defs.svh"

package radio_pkg;

  // Settings bus, one write per cycle with stb high
  typedef struct packed {
    logic       stb;
    logic [7:0] addr;
    logic [31:0] data;
  } set_bus_t;

  // One stream beat, used for both TX input and RX output
  typedef struct packed {
    logic [`RADIO_SAMP_W-1:0] data;
    logic                     last;  // Final beat of a burst
  } samp_beat_t;

  // TIME_CTRL bit 0
  typedef enum logic {
    TIME_LOAD_NOW = 1'b0,
    TIME_LOAD_PPS = 1'b1
  } time_ctrl_t;

  // RX_CMD bits 31:30, count in bits 15:0
  typedef enum logic [1:0] {
    RX_CMD_STOP   = 2'd0,
    RX_CMD_FINITE = 2'd1,
    RX_CMD_CONT   = 2'd2
  } rx_cmd_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_RUN,
    RX_HALTING   // Next beat carries last
  } rx_state_t;

  typedef enum logic {
    TX_IDLE,
    TX_RUN
  } tx_state_t;

endpackage

//--- src/radio_timekeeper.sv
// Sample-time keeper
// Free-running 64-bit counter, loadable at once or on the next PPS edge,
// with capture of the time at the last PPS

`include "radio_defs.svh"

module radio_timekeeper import radio_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  set_bus_t                 i_set,
  input  logic                     i_pps,
  output logic [`RADIO_TIME_W-1:0] o_time,
  output logic [`RADIO_TIME_W-1:0] o_time_lastpps
);

  logic [31:0] pending_hi;
  logic [31:0] pending_lo;
  logic        armed;       // Load waits for PPS
  logic        pps_r;
  logic        pps_d;
  logic        pps_edge;
  logic        ctrl_wr;
  time_ctrl_t  ctrl_mode;

  assign pps_edge  = pps_r & ~pps_d;
  assign ctrl_wr   = i_set.stb && (i_set.addr == `RADIO_SR_TIME_CTRL);
  assign ctrl_mode = time_ctrl_t'(i_set.data[0]);

  // Pending load value
  always_ff @(posedge clk) begin
    if (i_set.stb && i_set.addr == `RADIO_SR_TIME_HI) pending_hi <= i_set.data;
    if (i_set.stb && i_set.addr == `RADIO_SR_TIME_LO) pending_lo <= i_set.data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pps_r          <= 1'b0;
      pps_d          <= 1'b0;
      armed          <= 1'b0;
      o_time         <= '0;
      o_time_lastpps <= '0;
    end else begin
      pps_r <= i_pps;   // One register stage on the PPS input
      pps_d <= pps_r;
      if (pps_edge) o_time_lastpps <= o_time;
      if (ctrl_wr && ctrl_mode == TIME_LOAD_NOW) begin
        o_time <= {pending_hi, pending_lo};
        armed  <= 1'b0;
      end else if (pps_edge && armed) begin
        o_time <= {pending_hi, pending_lo};
        armed  <= 1'b0;
      end else begin
        o_time <= o_time + 1'b1;
      end
      if (ctrl_wr && ctrl_mode == TIME_LOAD_PPS) armed <= 1'b1;
    end
  end

endmodule

//--- src/radio_tx_control.sv
// TX burst control
// Holds one stream sample ahead of the converter and releases it on each
// TX strobe, ends bursts on last or on underflow

`include "radio_defs.svh"

module radio_tx_control import radio_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  samp_beat_t               i_tx_beat,
  input  logic                     i_tx_valid,
  output logic                     o_tx_ready,
  input  logic                     i_strobe,
  output logic                     o_run,
  output logic [`RADIO_SAMP_W-1:0] o_sample,
  output logic [31:0]              o_underflows
);

  tx_state_t  state;
  samp_beat_t hold;        // One-entry holding register
  logic       hold_full;
  logic       last_sent;   // Burst ends on the next strobe
  logic       take;
  logic       move;

  assign o_tx_ready = ~hold_full;
  assign o_run      = (state == TX_RUN);
  assign take       = i_tx_valid && o_tx_ready;
  assign move       = i_strobe && hold_full && !(state == TX_RUN && last_sent);

  always_ff @(posedge clk) begin
    if (take) hold <= i_tx_beat;
    if (move) o_sample <= hold.data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= TX_IDLE;
      hold_full    <= 1'b0;
      last_sent    <= 1'b0;
      o_underflows <= '0;
    end else begin
      if (take) hold_full <= 1'b1;
      if (move) begin
        hold_full <= 1'b0;
        last_sent <= hold.last;
      end
      case (state)
        TX_IDLE: begin
          if (move) state <= TX_RUN;
        end
        TX_RUN: begin
          if (i_strobe) begin
            if (last_sent) begin
              state     <= TX_IDLE;   // Burst finished cleanly
              last_sent <= 1'b0;
            end else if (!hold_full) begin
              state        <= TX_IDLE; // Nothing to send
              o_underflows <= o_underflows + 1'b1;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

//--- src/radio_rx_control.sv
// RX burst control
// Decodes RX commands, captures strobed converter samples and sends them
// as framed stream beats, dropping samples and counting overflows when stalled

`include "radio_defs.svh"

module radio_rx_control import radio_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  set_bus_t                 i_set,
  input  logic                     i_strobe,
  input  logic [`RADIO_SAMP_W-1:0] i_sample,
  output samp_beat_t               o_rx_beat,
  output logic                     o_rx_valid,
  input  logic                     i_rx_ready,
  output logic                     o_run,
  output logic [31:0]              o_overflows
);

  rx_state_t   state;
  logic [15:0] remaining;   // Beats left in a finite burst
  logic        cont;        // Continuous mode, ends only on halt
  logic        cmd_wr;
  logic        halt_wr;
  rx_cmd_t     cmd_op;
  logic        stalled;
  logic        load;
  logic        beat_last;

  assign cmd_wr    = i_set.stb && (i_set.addr == `RADIO_SR_RX_CMD);
  assign halt_wr   = i_set.stb && (i_set.addr == `RADIO_SR_RX_HALT);
  assign cmd_op    = rx_cmd_t'(i_set.data[31:30]);
  assign stalled   = o_rx_valid && !i_rx_ready;
  assign load      = i_strobe && (state != RX_IDLE) && !stalled;
  assign beat_last = (state == RX_HALTING) || (!cont && remaining == 16'd1);
  assign o_run     = (state != RX_IDLE);

  always_ff @(posedge clk) begin
    if (load) o_rx_beat <= '{data: i_sample, last: beat_last};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= RX_IDLE;
      remaining   <= '0;
      cont        <= 1'b0;
      o_rx_valid  <= 1'b0;
      o_overflows <= '0;
    end else begin
      if (o_rx_valid && i_rx_ready) o_rx_valid <= 1'b0;
      if (i_strobe && state != RX_IDLE) begin
        if (stalled) begin
          o_overflows <= o_overflows + 1'b1;  // Sample lost, pending beat kept
          state       <= RX_IDLE;
        end else begin
          o_rx_valid <= 1'b1;
          remaining  <= remaining - 1'b1;
          if (beat_last) state <= RX_IDLE;
        end
      end

      // Commands override the strobe result in the same cycle
      if (cmd_wr) begin
        case (cmd_op)
          RX_CMD_FINITE: begin
            cont      <= 1'b0;
            remaining <= i_set.data[15:0];
            state     <= (i_set.data[15:0] == 16'd0) ? RX_IDLE : RX_RUN;
          end
          RX_CMD_CONT: begin
            cont  <= 1'b1;
            state <= RX_RUN;
          end
          default: state <= RX_IDLE;   // Stop at once, no last
        endcase
      end else if (halt_wr && state == RX_RUN) begin
        state <= RX_HALTING;
      end
    end
  end

endmodule

//--- src/radio_core.sv
// Single-channel radio core at the sample clock rate
// Setting registers, readback mux, timekeeper, TX and RX burst control
// and the digital TX to RX loopback

`include "radio_defs.svh"

module radio_core import radio_pkg::*; #(
  parameter int RADIO_NUM = 0
) (
  input  logic                     clk,
  input  logic                     reset,
  // Settings bus and readback
  input  set_bus_t                 i_set,
  input  logic [7:0]               i_rb_addr,
  output logic [63:0]              o_rb_data,
  // Converter side
  input  logic [`RADIO_SAMP_W-1:0] i_rx,
  input  logic                     i_rx_stb,
  output logic [`RADIO_SAMP_W-1:0] o_tx,
  input  logic                     i_tx_stb,
  input  logic                     i_pps,
  // Sample streams
  input  samp_beat_t               i_tx_beat,
  input  logic                     i_tx_valid,
  output logic                     o_tx_ready,
  output samp_beat_t               o_rx_beat,
  output logic                     o_rx_valid,
  input  logic                     i_rx_ready
);

  logic                     loopback;
  logic [31:0]              test_reg;
  logic [`RADIO_SAMP_W-1:0] tx_idle;
  logic [`RADIO_TIME_W-1:0] vita_time;
  logic [`RADIO_TIME_W-1:0] vita_time_lastpps;
  logic                     tx_run;
  logic [`RADIO_SAMP_W-1:0] tx_sample;
  logic [31:0]              underflows;
  logic [31:0]              overflows;
  logic [`RADIO_SAMP_W-1:0] rx_sample;
  logic                     rx_stb;

  // Plain setting registers
  always_ff @(posedge clk) begin
    if (reset) begin
      loopback <= 1'b0;
      test_reg <= '0;
      tx_idle  <= '0;
    end else if (i_set.stb) begin
      if (i_set.addr == `RADIO_SR_LOOPBACK)   loopback <= i_set.data[0];
      if (i_set.addr == `RADIO_SR_TEST)       test_reg <= i_set.data;
      if (i_set.addr == `RADIO_SR_CODEC_IDLE) tx_idle  <= i_set.data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_rb_data <= '0;
    end else begin
      case (i_rb_addr)
        `RADIO_RB_VITA_TIME: o_rb_data <= vita_time;
        `RADIO_RB_LASTPPS:   o_rb_data <= vita_time_lastpps;
        `RADIO_RB_RX:        o_rb_data <= {i_rx, test_reg};
        `RADIO_RB_TXRX:      o_rb_data <= {o_tx, i_rx};
        `RADIO_RB_RADIO_NUM: o_rb_data <= {32'd0, RADIO_NUM[31:0]};
        `RADIO_RB_ERRORS:    o_rb_data <= {overflows, underflows};
        default:             o_rb_data <= '0;
      endcase
    end
  end

  radio_timekeeper u_timekeeper (
    .clk            (clk),
    .reset          (reset),
    .i_set          (i_set),
    .i_pps          (i_pps),
    .o_time         (vita_time),
    .o_time_lastpps (vita_time_lastpps)
  );

  radio_tx_control u_tx_control (
    .clk          (clk),
    .reset        (reset),
    .i_tx_beat    (i_tx_beat),
    .i_tx_valid   (i_tx_valid),
    .o_tx_ready   (o_tx_ready),
    .i_strobe     (i_tx_stb),
    .o_run        (tx_run),
    .o_sample     (tx_sample),
    .o_underflows (underflows)
  );

  assign o_tx = tx_run ? tx_sample : tx_idle;  // Idle word between bursts

  // Digital loopback TX -> RX
  assign rx_sample = loopback ? o_tx     : i_rx;
  assign rx_stb    = loopback ? i_tx_stb : i_rx_stb;

  radio_rx_control u_rx_control (
    .clk         (clk),
    .reset       (reset),
    .i_set       (i_set),
    .i_strobe    (rx_stb),
    .i_sample    (rx_sample),
    .o_rx_beat   (o_rx_beat),
    .o_rx_valid  (o_rx_valid),
    .i_rx_ready  (i_rx_ready),
    .o_run       (),
    .o_overflows (overflows)
  );

endmodule

//--- tb/radio_model.svh
// Reference model for the radio core testbench
// Expected RX beats, error counts and TX output, plus typed compare tasks

`ifndef RADIO_MODEL_SVH
`define RADIO_MODEL_SVH

int          err_cnt     = 0;
logic [31:0] m_unf       = '0;  // Underflows so far
logic [31:0] m_ovf       = '0;
logic [31:0] m_idle      = '0;  // Codec idle word
logic [31:0] m_tx_out    = '0;  // Word o_tx should show
int          m_loop_left = 0;   // RX beats still due from TX under loopback
samp_beat_t  rx_exp[$];         // RX beats in delivery order

function automatic samp_beat_t make_beat(input logic [31:0] d, input logic l);
  samp_beat_t b;
  b.data = d;
  b.last = l;
  return b;
endfunction

function void expect_rx(input logic [31:0] d, input logic l);
  rx_exp.push_back(make_beat(d, l));
endfunction

// Under loopback each TX strobe hands the current o_tx word to RX
function void predict_loopback();
  if (m_loop_left > 0) begin
    expect_rx(m_tx_out, m_loop_left == 1);
    m_loop_left--;
  end
endfunction

function logic [63:0] errors_word();
  return {m_ovf, m_unf};  // Overflows high, underflows low
endfunction

task report_error(input string msg);
  $display("ERROR at %0t: %s", $time, msg);
  err_cnt++;
endtask

task check_rb(input string name, input logic [63:0] exp, input logic [63:0] act);
  if (act !== exp) begin
    $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
    err_cnt++;
  end
endtask

task check_beat(input string name, input samp_beat_t exp, input samp_beat_t act);
  if (act !== exp) begin
    $display("MISMATCH at %0t: %s expected data %h last %b got data %h last %b",
             $time, name, exp.data, exp.last, act.data, act.last);
    err_cnt++;
  end
endtask

task check_sample(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (act !== exp) begin
    $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
    err_cnt++;
  end
endtask

`endif

//--- tb/tb_radio_core.sv
// Testbench for the single-channel radio core
// Random settings, stream and strobe stimulus checked against a reference model

`include "radio_defs.svh"

module tb_radio_core import radio_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int RADIO_NUM_P = 3;
  // Reset plus rough worst-case lengths of the six tests and a margin
  localparam int TIMEOUT_CYCLES = 10 + 20 + 80 + 300 + 20 + 600 + 400 + 1000;

  logic                     clk;
  logic                     reset;
  set_bus_t                 i_set;
  logic [7:0]               i_rb_addr;
  logic [63:0]              o_rb_data;
  logic [`RADIO_SAMP_W-1:0] i_rx;
  logic                     i_rx_stb;
  logic [`RADIO_SAMP_W-1:0] o_tx;
  logic                     i_tx_stb;
  logic                     i_pps;
  samp_beat_t               i_tx_beat;
  logic                     i_tx_valid;
  logic                     o_tx_ready;
  samp_beat_t               o_rx_beat;
  logic                     o_rx_valid;
  logic                     i_rx_ready;
  int                       tests_run    = 0;
  int                       tests_failed = 0;
  int                       err_mark     = 0;

  `include "radio_model.svh"

  radio_core #(.RADIO_NUM(RADIO_NUM_P)) i_radio_core (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic coin(input int pct);
    return ($urandom % 100) < pct;
  endfunction

  // Check RX beats as they transfer and advance the clock
  task automatic tick();
    if (o_rx_valid && i_rx_ready) begin
      if (rx_exp.size() == 0) begin
        report_error("RX stream delivered a beat that no strobe should have produced");
      end else begin
        check_beat("o_rx_beat", rx_exp.pop_front(), o_rx_beat);
      end
    end
    @(posedge clk);
    #2;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    i_set.stb  = 1'b1;
    i_set.addr = addr;
    i_set.data = data;
    tick();
    i_set.stb = 1'b0;
  endtask

  task automatic read_rb(input logic [7:0] addr, output logic [63:0] data);
    i_rb_addr = addr;
    tick();
    data = o_rb_data;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == err_mark) begin
      $display("Test %0d (%s): ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d (%s): failed with %0d errors", tests_run, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // Strobe only while a sample is held so the burst has no underflow
  task automatic tx_burst(input int n);
    logic [31:0] data_q[$];
    int          taken;
    int          moved;
    logic        rdy;
    for (int k = 0; k < n; k++) data_q.push_back($urandom);
    taken = 0;
    moved = 0;
    while (moved < n) begin
      rdy = o_tx_ready;
      if (!i_tx_valid && taken < n && coin(60)) begin
        i_tx_beat  = make_beat(data_q[taken], taken == n - 1);
        i_tx_valid = 1'b1;
      end
      i_tx_stb = !rdy && !i_tx_stb && coin(50);
      if (i_tx_stb) predict_loopback();
      tick();
      if (i_tx_valid && rdy) begin
        i_tx_valid = 1'b0;
        taken++;
      end
      if (i_tx_stb) begin
        m_tx_out = data_q[moved];
        moved++;
        check_sample("o_tx", m_tx_out, o_tx);
      end
    end
    i_tx_stb = 1'b0;
    tick();
    i_tx_stb = 1'b1;  // Strobe after the last sample ends the burst
    predict_loopback();
    tick();
    i_tx_stb = 1'b0;
    m_tx_out = m_idle;
    check_sample("o_tx idle", m_idle, o_tx);
  endtask

  // Strobe n samples with random ready and never into a stalled beat
  task automatic rx_pump(input int n, input logic last_at_end);
    int sent;
    sent = 0;
    while (sent < n || rx_exp.size() > 0) begin
      i_rx_ready = coin(60);
      i_rx       = $urandom;
      i_rx_stb   = sent < n && !i_rx_stb && coin(40) && (!o_rx_valid || i_rx_ready);
      if (i_rx_stb) begin
        expect_rx(i_rx, last_at_end && sent == n - 1);
        sent++;
      end
      tick();
    end
    i_rx_stb = 1'b0;
  endtask

  task automatic rx_quiet_check();
    i_rx_ready = 1'b1;
    repeat (6) begin
      i_rx_stb = !i_rx_stb;  // Strobes with RX idle must give no beats
      tick();
    end
  endtask

  initial begin
    logic [63:0] rb;
    logic [63:0] load;
    logic [63:0] load2;
    logic [63:0] pps_time;
    logic [31:0] val;
    int          n;
    int          elapsed;
    void'($urandom(32'hbc1e_f4e9));
    clk        = 1'b0;
    reset      = 1'b1;
    i_set      = '0;
    i_rb_addr  = '0;
    i_rx       = '0;
    i_rx_stb   = 1'b0;
    i_tx_stb   = 1'b0;
    i_pps      = 1'b0;
    i_tx_beat  = '0;
    i_tx_valid = 1'b0;
    i_rx_ready = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    val = $urandom;
    write_reg(`RADIO_SR_TEST, val);
    read_rb(`RADIO_RB_RADIO_NUM, rb);
    check_rb("o_rb_data radio_num", {32'd0, 32'(RADIO_NUM_P)}, rb);
    i_rx = $urandom;
    read_rb(`RADIO_RB_RX, rb);
    check_rb("o_rb_data rx", {i_rx, val}, rb);
    end_test("register readback");

    load      = {$urandom, $urandom};
    i_rb_addr = `RADIO_RB_VITA_TIME;
    write_reg(`RADIO_SR_TIME_HI, load[63:32]);
    write_reg(`RADIO_SR_TIME_LO, load[31:0]);
    write_reg(`RADIO_SR_TIME_CTRL, {31'd0, TIME_LOAD_NOW});
    elapsed = 0;
    n       = 1 + int'($urandom % 16);
    repeat (n) begin
      tick();
      elapsed++;
    end
    check_rb("o_rb_data vita_time", load + 64'(elapsed - 1), o_rb_data);  // Read lags one
    load2 = {$urandom, $urandom};
    write_reg(`RADIO_SR_TIME_HI, load2[63:32]);
    write_reg(`RADIO_SR_TIME_LO, load2[31:0]);
    write_reg(`RADIO_SR_TIME_CTRL, {31'd0, TIME_LOAD_PPS});
    elapsed = elapsed + 3;
    n       = 2 + int'($urandom % 10);
    repeat (n) begin
      tick();
      elapsed++;
    end
    check_rb("o_rb_data vita_time armed", load + 64'(elapsed - 1), o_rb_data);
    i_pps = 1'b1;
    tick();          // PPS registered
    pps_time = load + 64'(elapsed + 1);
    tick();          // Edge seen so load and capture
    tick();
    check_rb("o_rb_data vita_time pps", load2, o_rb_data);
    i_pps = 1'b0;
    read_rb(`RADIO_RB_LASTPPS, rb);
    check_rb("o_rb_data lastpps", pps_time, rb);
    end_test("timekeeper");

    m_idle = $urandom;
    write_reg(`RADIO_SR_CODEC_IDLE, m_idle);
    m_tx_out = m_idle;
    check_sample("o_tx idle", m_idle, o_tx);
    read_rb(`RADIO_RB_TXRX, rb);
    check_rb("o_rb_data txrx", {m_idle, i_rx}, rb);
    tx_burst(4 + int'($urandom % 9));
    end_test("tx burst");

    val        = $urandom;
    i_tx_beat  = make_beat(val, 1'b0);
    i_tx_valid = 1'b1;
    tick();
    i_tx_valid = 1'b0;
    i_tx_stb   = 1'b1;
    tick();
    i_tx_stb = 1'b0;
    check_sample("o_tx", val, o_tx);
    tick();
    i_tx_stb = 1'b1;  // Running with nothing held
    tick();
    i_tx_stb = 1'b0;
    m_unf++;
    check_sample("o_tx idle", m_idle, o_tx);
    read_rb(`RADIO_RB_ERRORS, rb);
    check_rb("o_rb_data errors", errors_word(), rb);
    end_test("tx underflow");

    n = 1 + int'($urandom % 20);
    write_reg(`RADIO_SR_RX_CMD, {RX_CMD_FINITE, 14'd0, 16'(n)});
    rx_pump(n, 1'b1);
    rx_quiet_check();
    write_reg(`RADIO_SR_RX_CMD, {RX_CMD_CONT, 30'd0});
    rx_pump(2 + int'($urandom % 10), 1'b0);
    write_reg(`RADIO_SR_RX_HALT, 32'd0);
    rx_pump(1, 1'b1);
    rx_quiet_check();
    end_test("rx finite and continuous");

    i_rx_ready = 1'b0;
    write_reg(`RADIO_SR_RX_CMD, {RX_CMD_FINITE, 14'd0, 16'd8});
    i_rx     = $urandom;
    i_rx_stb = 1'b1;
    expect_rx(i_rx, 1'b0);
    tick();
    i_rx_stb = 1'b0;
    tick();
    i_rx     = $urandom;
    i_rx_stb = 1'b1;  // Arrives while the first beat is stalled
    tick();
    i_rx_stb = 1'b0;
    m_ovf++;
    if (o_rx_valid !== 1'b1) report_error("stalled RX beat was dropped after the overflow");
    i_rx_ready = 1'b1;
    tick();
    if (rx_exp.size() != 0) report_error("stalled RX beat was never delivered");
    rx_quiet_check();  // Overflow leaves RX idle
    read_rb(`RADIO_RB_ERRORS, rb);
    check_rb("o_rb_data errors", errors_word(), rb);
    write_reg(`RADIO_SR_LOOPBACK, 32'd1);
    n           = 3 + int'($urandom % 8);
    m_loop_left = n + 1;  // Idle word first and then every TX sample
    write_reg(`RADIO_SR_RX_CMD, {RX_CMD_FINITE, 14'd0, 16'(n + 1)});
    tx_burst(n);
    repeat (8) begin
      if (rx_exp.size() > 0) tick();
    end
    if (rx_exp.size() != 0) report_error("loopback RX beats missing after the TX burst");
    write_reg(`RADIO_SR_LOOPBACK, 32'd0);
    end_test("rx overflow and loopback");

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+src
+incdir+tb
src/radio_pkg.sv
src/radio_timekeeper.sv
src/radio_tx_control.sv
src/radio_rx_control.sv
src/radio_core.sv
tb/tb_radio_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the radio core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f \
  --top-module tb_radio_core --Mdir obj_dir -o tb_radio_core

./obj_dir/tb_radio_core | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"
